//--- Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/ic_fifo.sv
`timescale 1ns/1ps

module ic_fifo #(
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             full,
    output logic             empty
);

    // pointers carry one extra wrap bit
    logic [WIDTH-1:0] mem [icache_pkg::FIFO_DEPTH];
    logic [$clog2(icache_pkg::FIFO_DEPTH):0] wr_ptr;
    logic [$clog2(icache_pkg::FIFO_DEPTH):0] rd_ptr;
    logic do_push;
    logic do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[$clog2(icache_pkg::FIFO_DEPTH)] != rd_ptr[$clog2(icache_pkg::FIFO_DEPTH)])
                 && (wr_ptr[$clog2(icache_pkg::FIFO_DEPTH)-1:0]
                     == rd_ptr[$clog2(icache_pkg::FIFO_DEPTH)-1:0]);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[$clog2(icache_pkg::FIFO_DEPTH)-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // head is always on the output
    assign pop_data = mem[rd_ptr[$clog2(icache_pkg::FIFO_DEPTH)-1:0]];

endmodule

//--- rtl/ic_line_store.sv
`timescale 1ns/1ps

module ic_line_store (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           flush_i_valid,
    input  logic                                           rd_en,
    input  icache_pkg::index_t                             rd_index,
    output icache_pkg::tag_t  [icache_pkg::WAYS-1:0]       rd_tags,
    output icache_pkg::line_t [icache_pkg::WAYS-1:0]       rd_lines,
    output logic              [icache_pkg::WAYS-1:0]       rd_valid,
    input  logic                                           line_wen,
    input  icache_pkg::line_write_t                        line_wr,
    output icache_pkg::way_t                               victim_way
);

    icache_pkg::tag_t  tag_mem  [icache_pkg::WAYS][icache_pkg::SETS];
    icache_pkg::line_t data_mem [icache_pkg::WAYS][icache_pkg::SETS];
    logic [icache_pkg::WAYS-1:0][icache_pkg::SETS-1:0] valid_q;
    logic [7:0] lfsr;

    // ******************************************************************
    // arrays
    always_ff @(posedge clk) begin
        if (line_wen) begin
            tag_mem[line_wr.way][line_wr.index]  <= line_wr.tag;
            data_mem[line_wr.way][line_wr.index] <= line_wr.line;
        end
    end

    // read data holds until the next rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                rd_tags[w]  <= tag_mem[w][rd_index];
                rd_lines[w] <= data_mem[w][rd_index];
            end
        end
    end

    // ******************************************************************
    // valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush_i_valid) begin
            valid_q <= '0;
        end else if (line_wen) begin
            valid_q[line_wr.way][line_wr.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= '0;
        end else if (rd_en) begin
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                rd_valid[w] <= valid_q[w][rd_index];
            end
        end
    end

    // ******************************************************************
    // replacement, x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= 8'hA5;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    assign victim_way = lfsr[$bits(icache_pkg::way_t)-1:0];

endmodule

//--- rtl/ic_lookup_stage.sv
`timescale 1ns/1ps

module ic_lookup_stage (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       req_empty,
    input  icache_pkg::addr_t                          req_addr,
    output logic                                       req_pop,
    input  icache_pkg::tag_t  [icache_pkg::WAYS-1:0]   rd_tags,
    input  icache_pkg::line_t [icache_pkg::WAYS-1:0]   rd_lines,
    input  logic              [icache_pkg::WAYS-1:0]   rd_valid,
    output logic                                       miss,
    output icache_pkg::addr_t                          miss_addr,
    input  logic                                       send_valid,
    input  icache_pkg::fetch_resp_t                    send_resp,
    output logic                                       send_done,
    input  logic                                       resp_full,
    output logic                                       resp_push,
    output icache_pkg::fetch_resp_t                    resp_data
);

    logic                    stage_valid;
    icache_pkg::addr_t       stage_addr;
    logic                    miss_sent;
    logic [icache_pkg::WAYS-1:0] hit_vec;
    logic                    hit;
    logic                    hit_push;
    icache_pkg::line_t       hit_line;
    icache_pkg::word_t       hit_word;

    // tag compare
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            hit_vec[w] = rd_valid[w]
                       && (rd_tags[w] == stage_addr[icache_pkg::ADDR_W-1:icache_pkg::TAG_LSB]);
            if (hit_vec[w]) begin
                hit_line = hit_line | rd_lines[w];
            end
        end
    end

    assign hit      = |hit_vec;
    assign hit_word = stage_addr[icache_pkg::WORD_SEL_BIT]
                    ? hit_line[icache_pkg::LINE_W-1:icache_pkg::WORD_W]
                    : hit_line[icache_pkg::WORD_W-1:0];

    // one pulse per miss, then wait for the refill reply
    assign miss      = stage_valid & ~hit & ~miss_sent;
    assign miss_addr = stage_addr;

    assign hit_push  = stage_valid & hit & ~miss_sent & ~resp_full;
    assign send_done = miss_sent & send_valid & ~resp_full;
    assign resp_push = hit_push | send_done;
    assign req_pop   = ~req_empty & (~stage_valid | resp_push);

    always_comb begin
        if (send_valid) begin
            resp_data = send_resp;
        end else begin
            resp_data.resp = icache_pkg::RESP_OKAY;
            resp_data.data = hit_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
            miss_sent   <= 1'b0;
        end else begin
            if (req_pop) begin
                stage_valid <= 1'b1;
            end else if (resp_push) begin
                stage_valid <= 1'b0;
            end
            if (miss) begin
                miss_sent <= 1'b1;
            end else if (send_done) begin
                miss_sent <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_pop) begin
            stage_addr <= req_addr;
        end
    end

endmodule

//--- rtl/ic_refill.sv
`timescale 1ns/1ps

module ic_refill (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    miss,
    input  icache_pkg::addr_t       miss_addr,
    input  icache_pkg::way_t        victim_way,
    output logic                    arvalid,
    input  logic                    arready,
    output icache_pkg::addr_t       araddr,
    input  logic                    rvalid,
    input  icache_pkg::axi_r_t      rbeat,
    output logic                    line_wen,
    output icache_pkg::line_write_t line_wr,
    output logic                    send_valid,
    output icache_pkg::fetch_resp_t send_resp,
    input  logic                    send_done
);

    icache_pkg::refill_state_t state;
    icache_pkg::resp_t         resp_q;
    icache_pkg::addr_t         addr_q;
    icache_pkg::line_t         line_q;
    logic                      beat_bad;
    logic                      in_pmem;

    assign beat_bad = |rbeat.resp;
    assign in_pmem  = (addr_q >= icache_pkg::PMEM_START) && (addr_q <= icache_pkg::PMEM_END);

    // ******************************************************************
    // miss FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= icache_pkg::IDLE;
            resp_q <= icache_pkg::RESP_OKAY;
        end else begin
            case (state)
                icache_pkg::IDLE: begin
                    if (miss) begin
                        state  <= icache_pkg::WAIT_ARREADY;
                        resp_q <= icache_pkg::RESP_OKAY;
                    end
                end
                icache_pkg::WAIT_ARREADY: begin
                    if (arready) begin
                        state <= icache_pkg::WAIT_BEAT0;
                    end
                end
                icache_pkg::WAIT_BEAT0: begin
                    if (rvalid) begin
                        if (rbeat.last) begin
                            // burst too short
                            state  <= icache_pkg::SEND_DATA;
                            resp_q <= icache_pkg::RESP_ERR;
                        end else if (beat_bad) begin
                            state  <= icache_pkg::BEAT0_ERROR;
                            resp_q <= icache_pkg::RESP_ERR;
                        end else begin
                            state <= icache_pkg::WAIT_BEAT1;
                        end
                    end
                end
                icache_pkg::BEAT0_ERROR: begin
                    if (rvalid && rbeat.last) begin
                        state <= icache_pkg::SEND_DATA;
                    end
                end
                icache_pkg::WAIT_BEAT1: begin
                    if (rvalid) begin
                        if (beat_bad || !rbeat.last) begin
                            state  <= rbeat.last ? icache_pkg::SEND_DATA
                                                 : icache_pkg::BEAT0_ERROR;
                            resp_q <= icache_pkg::RESP_ERR;
                        end else if (!in_pmem) begin
                            state <= icache_pkg::SEND_DATA;
                        end else begin
                            state <= icache_pkg::WRITE_LINE;
                        end
                    end
                end
                icache_pkg::WRITE_LINE: begin
                    state <= icache_pkg::SEND_DATA;
                end
                icache_pkg::SEND_DATA: begin
                    if (send_done) begin
                        state <= icache_pkg::IDLE;
                    end
                end
                default: begin
                    state <= icache_pkg::IDLE;
                end
            endcase
        end
    end

    // line assembly, beat 0 low half
    always_ff @(posedge clk) begin
        if (state == icache_pkg::IDLE && miss) begin
            addr_q <= miss_addr;
        end
        if (state == icache_pkg::WAIT_BEAT0 && rvalid) begin
            line_q[icache_pkg::WORD_W-1:0] <= rbeat.data;
        end
        if (state == icache_pkg::WAIT_BEAT1 && rvalid) begin
            line_q[icache_pkg::LINE_W-1:icache_pkg::WORD_W] <= rbeat.data;
        end
    end

    // ******************************************************************
    // outputs
    assign arvalid = (state == icache_pkg::WAIT_ARREADY);
    assign araddr  = {addr_q[icache_pkg::ADDR_W-1:icache_pkg::INDEX_LSB],
                      {icache_pkg::INDEX_LSB{1'b0}}};

    assign line_wen      = (state == icache_pkg::WRITE_LINE);
    assign line_wr.index = addr_q[icache_pkg::INDEX_LSB +: $bits(icache_pkg::index_t)];
    assign line_wr.way   = victim_way;
    assign line_wr.tag   = addr_q[icache_pkg::ADDR_W-1:icache_pkg::TAG_LSB];
    assign line_wr.line  = line_q;

    assign send_valid     = (state == icache_pkg::SEND_DATA);
    assign send_resp.resp = resp_q;
    assign send_resp.data = addr_q[icache_pkg::WORD_SEL_BIT]
                          ? line_q[icache_pkg::LINE_W-1:icache_pkg::WORD_W]
                          : line_q[icache_pkg::WORD_W-1:0];

endmodule

//--- rtl/icache_pkg.sv
package icache_pkg;

    // geometry
    localparam int ADDR_W       = 64;
    localparam int WORD_W       = 64;
    localparam int LINE_W       = 128;
    localparam int WAYS         = 2;
    localparam int SETS         = 64;
    localparam int INDEX_LSB    = 4;
    localparam int TAG_LSB      = 10;
    localparam int WORD_SEL_BIT = 3;
    localparam int FIFO_DEPTH   = 8;

    // cacheable window
    localparam logic [ADDR_W-1:0] PMEM_START = 64'h0000_0000_8000_0000;
    localparam logic [ADDR_W-1:0] PMEM_END   = 64'h0000_0000_FFFF_FFFF;

    localparam logic [1:0] RESP_OKAY = 2'd0;
    localparam logic [1:0] RESP_ERR  = 2'd3;

    typedef logic [ADDR_W-1:0]         addr_t;
    typedef logic [WORD_W-1:0]         word_t;
    typedef logic [LINE_W-1:0]         line_t;
    typedef logic [ADDR_W-TAG_LSB-1:0] tag_t;
    typedef logic [$clog2(SETS)-1:0]   index_t;
    typedef logic [$clog2(WAYS)-1:0]   way_t;
    typedef logic [1:0]                resp_t;

    typedef struct packed {
        resp_t resp;
        word_t data;
    } fetch_resp_t;

    // one read data beat from the bus
    typedef struct packed {
        resp_t resp;
        word_t data;
        logic  last;
    } axi_r_t;

    typedef struct packed {
        index_t index;
        way_t   way;
        tag_t   tag;
        line_t  line;
    } line_write_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_ARREADY,
        WAIT_BEAT0,
        BEAT0_ERROR,
        WAIT_BEAT1,
        WRITE_LINE,
        SEND_DATA
    } refill_state_t;

endpackage

//--- rtl/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_i_valid,
    input  logic                ifu_arvalid,
    output logic                ifu_arready,
    input  icache_pkg::addr_t   ifu_araddr,
    output logic                ifu_rvalid,
    input  logic                ifu_rready,
    output icache_pkg::resp_t   ifu_rresp,
    output icache_pkg::word_t   ifu_rdata,
    output logic                icache_arvalid,
    input  logic                icache_arready,
    output icache_pkg::addr_t   icache_araddr,
    input  logic                icache_rvalid,
    input  icache_pkg::axi_r_t  icache_rbeat
);

    logic                    req_full;
    logic                    req_empty;
    logic                    req_pop;
    icache_pkg::addr_t       req_addr;
    logic                    resp_full;
    logic                    resp_empty;
    logic                    resp_push;
    icache_pkg::fetch_resp_t resp_data;
    icache_pkg::fetch_resp_t resp_head;

    icache_pkg::tag_t  [icache_pkg::WAYS-1:0] rd_tags;
    icache_pkg::line_t [icache_pkg::WAYS-1:0] rd_lines;
    logic              [icache_pkg::WAYS-1:0] rd_valid;
    icache_pkg::way_t        victim_way;
    logic                    line_wen;
    icache_pkg::line_write_t line_wr;

    logic                    miss;
    icache_pkg::addr_t       miss_addr;
    logic                    send_valid;
    icache_pkg::fetch_resp_t send_resp;
    logic                    send_done;

    // fetch side handshakes
    assign ifu_arready = ~req_full;
    assign ifu_rvalid  = ~resp_empty;
    assign ifu_rresp   = resp_head.resp;
    assign ifu_rdata   = resp_head.data;

    ic_fifo #(
        .WIDTH (icache_pkg::ADDR_W)
    ) u_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (ifu_arvalid & ifu_arready),
        .push_data (ifu_araddr),
        .pop       (req_pop),
        .pop_data  (req_addr),
        .full      (req_full),
        .empty     (req_empty)
    );

    ic_fifo #(
        .WIDTH ($bits(icache_pkg::fetch_resp_t))
    ) u_resp_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (resp_push),
        .push_data (resp_data),
        .pop       (ifu_rvalid & ifu_rready),
        .pop_data  (resp_head),
        .full      (resp_full),
        .empty     (resp_empty)
    );

    ic_line_store u_line_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i_valid (flush_i_valid),
        .rd_en         (req_pop),
        .rd_index      (req_addr[icache_pkg::INDEX_LSB +: $bits(icache_pkg::index_t)]),
        .rd_tags       (rd_tags),
        .rd_lines      (rd_lines),
        .rd_valid      (rd_valid),
        .line_wen      (line_wen),
        .line_wr       (line_wr),
        .victim_way    (victim_way)
    );

    ic_lookup_stage u_lookup (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_empty  (req_empty),
        .req_addr   (req_addr),
        .req_pop    (req_pop),
        .rd_tags    (rd_tags),
        .rd_lines   (rd_lines),
        .rd_valid   (rd_valid),
        .miss       (miss),
        .miss_addr  (miss_addr),
        .send_valid (send_valid),
        .send_resp  (send_resp),
        .send_done  (send_done),
        .resp_full  (resp_full),
        .resp_push  (resp_push),
        .resp_data  (resp_data)
    );

    ic_refill u_refill (
        .clk        (clk),
        .rst_n      (rst_n),
        .miss       (miss),
        .miss_addr  (miss_addr),
        .victim_way (victim_way),
        .arvalid    (icache_arvalid),
        .arready    (icache_arready),
        .araddr     (icache_araddr),
        .rvalid     (icache_rvalid),
        .rbeat      (icache_rbeat),
        .line_wen   (line_wen),
        .line_wr    (line_wr),
        .send_valid (send_valid),
        .send_resp  (send_resp),
        .send_done  (send_done)
    );

endmodule

//--- sim.f
rtl/icache_pkg.sv
rtl/ic_fifo.sv
rtl/ic_line_store.sv
rtl/ic_lookup_stage.sv
rtl/ic_refill.sv
rtl/icache_top.sv
tb/icache_tb.sv

//--- tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int RESET_CYCLES = 16;
    localparam int COLD_REQS    = 3;
    localparam int STREAM_REQS  = 40;
    localparam int ERR_REQS     = 2;
    localparam int UNC_REQS     = 3;
    localparam int FENCE_REQS   = 3;
    localparam int BP_REQS      = 60;
    localparam int TOTAL_REQS   = COLD_REQS + STREAM_REQS + ERR_REQS + UNC_REQS
                                + FENCE_REQS + BP_REQS;

    localparam icache_pkg::addr_t COLD_ADDR = 64'h0000_0000_8000_1230;
    localparam icache_pkg::addr_t ERR_ADDR  = 64'h0000_0000_9000_0440;
    localparam icache_pkg::addr_t UNC_ADDR  = 64'h0000_0000_0000_2340;
    localparam icache_pkg::addr_t BP_BASE   = 64'h0000_0000_8040_0280;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    flush_i_valid;
    logic                    ifu_arvalid;
    logic                    ifu_arready;
    icache_pkg::addr_t       ifu_araddr;
    logic                    ifu_rvalid;
    logic                    ifu_rready = 1'b1;
    icache_pkg::resp_t       ifu_rresp;
    icache_pkg::word_t       ifu_rdata;
    logic                    icache_arvalid;
    logic                    icache_arready;
    icache_pkg::addr_t       icache_araddr;
    logic                    icache_rvalid;
    icache_pkg::axi_r_t      icache_rbeat;

    logic [31:0]             rng_state = 32'd58046;
    logic                    stress = 1'b0;
    string                   test_name = "reset";
    int                      errors = 0;
    int                      checks = 0;
    int                      ar_count = 0;
    int                      exp_ar = 0;
    icache_pkg::fetch_resp_t expect_q [$];
    icache_pkg::addr_t       ar_q [$];
    bit                      cached_lines [icache_pkg::addr_t];

    always #4 clk = ~clk;

    icache_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i_valid  (flush_i_valid),
        .ifu_arvalid    (ifu_arvalid),
        .ifu_arready    (ifu_arready),
        .ifu_araddr     (ifu_araddr),
        .ifu_rvalid     (ifu_rvalid),
        .ifu_rready     (ifu_rready),
        .ifu_rresp      (ifu_rresp),
        .ifu_rdata      (ifu_rdata),
        .icache_arvalid (icache_arvalid),
        .icache_arready (icache_arready),
        .icache_araddr  (icache_araddr),
        .icache_rvalid  (icache_rvalid),
        .icache_rbeat   (icache_rbeat)
    );

    // ******************************************************************
    // random numbers and reference model
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned next_rand(input int unsigned range);
        rng_state = xorshift32(rng_state);
        return rng_state % range;
    endfunction

    // memory contents, a hash of the word address
    function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t a);
        icache_pkg::word_t w;
        w = a >> 3;
        return (w * 64'h9E37_79B9_7F4A_7C15) ^ (w << 23) ^ 64'h0123_4567_89AB_CDEF;
    endfunction

    function automatic bit in_err_window(input icache_pkg::addr_t a);
        return (a >= 64'h0000_0000_9000_0000) && (a <= 64'h0000_0000_9000_FFFF);
    endfunction

    function automatic bit is_cacheable(input icache_pkg::addr_t a);
        return (a >= icache_pkg::PMEM_START) && (a <= icache_pkg::PMEM_END);
    endfunction

    function automatic icache_pkg::fetch_resp_t expect_resp(input icache_pkg::addr_t a);
        icache_pkg::fetch_resp_t r;
        if (in_err_window(a)) begin
            r.resp = icache_pkg::RESP_ERR;
            r.data = '0;
        end else begin
            r.resp = icache_pkg::RESP_OKAY;
            r.data = mem_word(a);
        end
        return r;
    endfunction

    // requests are looked up in order, so the line model follows accept order
    function automatic void note_request(input icache_pkg::addr_t a);
        icache_pkg::addr_t line_addr;
        line_addr = {a[icache_pkg::ADDR_W-1:4], 4'h0};
        expect_q.push_back(expect_resp(a));
        if (!cached_lines.exists(line_addr)) begin
            exp_ar++;
            ar_q.push_back(line_addr);
            if (is_cacheable(a) && !in_err_window(a)) begin
                cached_lines[line_addr] = 1'b1;
            end
        end
    endfunction

    // ******************************************************************
    // fetch side tasks
    task automatic send_req(input icache_pkg::addr_t a);
        @(negedge clk);
        ifu_arvalid = 1'b1;
        ifu_araddr  = a;
        while (!ifu_arready) begin
            @(negedge clk);
        end
        note_request(a);
    endtask

    task automatic end_reqs();
        @(negedge clk);
        ifu_arvalid = 1'b0;
    endtask

    task automatic drain();
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic fence_i();
        drain();
        @(negedge clk);
        flush_i_valid = 1'b1;
        @(negedge clk);
        flush_i_valid = 1'b0;
        cached_lines.delete();
    endtask

    task automatic start_test(input string name);
        test_name = name;
        fence_i();
    endtask

    task automatic finish_test();
        drain();
        checks++;
        assert (ar_count == exp_ar) else begin
            errors++;
            $display("Mismatch %s AR count expected %0d actual %0d",
                     test_name, exp_ar, ar_count);
        end
    endtask

    // fetch unit back-pressure
    always @(negedge clk) begin : fetch_ready
        ifu_rready = stress ? (next_rand(2) == 0) : 1'b1;
    end

    // AXI memory, one burst at a time
    initial begin : axi_memory
        icache_pkg::addr_t line_addr;
        icache_pkg::addr_t exp_line;
        int unsigned       gap;
        icache_arready = 1'b0;
        icache_rvalid  = 1'b0;
        icache_rbeat   = '0;
        wait (rst_n);
        forever begin
            @(negedge clk);
            if (icache_arvalid) begin
                gap = next_rand(stress ? 8 : 3);
                repeat (gap) @(negedge clk);
                icache_arready = 1'b1;
                line_addr      = icache_araddr;
                ar_count++;
                exp_line = (ar_q.size() > 0) ? ar_q.pop_front() : '1;
                checks++;
                assert (line_addr == exp_line) else begin
                    errors++;
                    $display("Mismatch %s AR address expected %h actual %h",
                             test_name, exp_line, line_addr);
                end
                @(negedge clk);
                icache_arready = 1'b0;
                for (int b = 0; b < 2; b++) begin
                    gap = next_rand(3);
                    repeat (gap) @(negedge clk);
                    icache_rvalid     = 1'b1;
                    icache_rbeat.data = (b == 0) ? mem_word(line_addr)
                                                 : mem_word(line_addr + 64'd8);
                    icache_rbeat.resp = (b == 1 && in_err_window(line_addr)) ? 2'd2 : 2'd0;
                    icache_rbeat.last = (b == 1);
                    @(negedge clk);
                    icache_rvalid = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin : compare_responses
        icache_pkg::fetch_resp_t exp_r;
        if (rst_n && ifu_rvalid && ifu_rready) begin
            assert (expect_q.size() > 0) else begin
                errors++;
                $display("%s: response arrived with no request outstanding", test_name);
            end
            if (expect_q.size() > 0) begin
                exp_r = expect_q.pop_front();
                checks++;
                // data of an error reply carries no meaning
                assert (ifu_rresp == exp_r.resp
                        && (exp_r.resp != icache_pkg::RESP_OKAY || ifu_rdata == exp_r.data))
                else begin
                    errors++;
                    $display("Mismatch %s expected %0d/%h actual %0d/%h", test_name,
                             exp_r.resp, exp_r.data, ifu_rresp, ifu_rdata);
                end
            end
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + TOTAL_REQS * 64) @(posedge clk);
        $display("watchdog expired with %0d responses outstanding", expect_q.size());
        $display("checks %0d errors %0d", checks, errors + 1);
        $display("tests failed");
        $finish;
    end

    // ******************************************************************
    // test sequence
    initial begin : main
        icache_pkg::addr_t a;
        int                k;
        int unsigned       pick;
        rst_n         = 1'b0;
        flush_i_valid = 1'b0;
        ifu_arvalid   = 1'b0;
        ifu_araddr    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        test_name = "cold_miss_hit";
        send_req(COLD_ADDR);
        send_req(COLD_ADDR);
        send_req(COLD_ADDR + 64'd8);
        end_reqs();
        finish_test();

        // one tag per set, two tags across the run
        start_test("streaming");
        for (int j = 0; j < STREAM_REQS; j++) begin
            k = j % 16;
            a = ((k % 2) != 0) ? 64'h0000_0000_8020_0000 : 64'h0000_0000_8010_0000;
            a = a + (64'(k) << 4) + (64'((j / 16) % 2) << 3);
            send_req(a);
        end
        end_reqs();
        finish_test();

        start_test("bus_error");
        send_req(ERR_ADDR);
        send_req(ERR_ADDR);
        end_reqs();
        finish_test();

        start_test("uncacheable");
        send_req(UNC_ADDR);
        send_req(UNC_ADDR);
        send_req(UNC_ADDR + 64'd8);
        end_reqs();
        finish_test();

        start_test("fence_i");
        send_req(COLD_ADDR);
        send_req(COLD_ADDR);
        end_reqs();
        fence_i();
        send_req(COLD_ADDR);
        end_reqs();
        finish_test();

        start_test("back_pressure");
        stress = 1'b1;
        for (int j = 0; j < BP_REQS; j++) begin
            pick = next_rand(16);
            if (pick < 12) begin
                a = BP_BASE + (64'(pick) << 4);
            end else if (pick < 14) begin
                a = 64'h0000_0000_9000_0800;
            end else begin
                a = 64'h0000_0000_4000_0100;
            end
            a = a + (64'(next_rand(2)) << 3);
            send_req(a);
            if (next_rand(4) == 0) begin
                end_reqs();
            end
        end
        end_reqs();
        finish_test();
        stress = 1'b0;

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
